//--- include/mf2_config.svh
//////////////////////////////////////////////////////////////////////
// Multiface Two constants
// Port numbers, vector addresses, memory windows and shadow slots
//////////////////////////////////////////////////////////////////////
`ifndef MF2_CONFIG_SVH
`define MF2_CONFIG_SVH

`define MF2_RAM_AWIDTH   13
`define MF2_NMI_VECTOR   16'h0066
`define MF2_HIDE_VECTOR  16'h0065
`define MF2_PAGE_PORT    16'hFEE8  // bit 1 set selects FEEA, page off
`define MF2_ROM_WINDOW   3'b000    // 0000-1FFF
`define MF2_RAM_WINDOW   3'b001    // 2000-3FFF

// I/O port high bytes
`define GA_PORT          8'h7F
`define CRTC_SEL_PORT    8'hBC
`define CRTC_VAL_PORT    8'hBD
`define PPI_PORT         8'hF7
`define ROMSEL_PORT      8'hDF

// Shadow slots in Multiface RAM
`define MF2_LOC_PEN_INDEX  13'h1FCF
`define MF2_LOC_PEN_BASE   13'h1F90
`define MF2_LOC_BORDER     13'h1FDF
`define MF2_LOC_MODE       13'h1FEF
`define MF2_LOC_BANKING    13'h1FFF
`define MF2_LOC_CRTC_SEL   13'h1CFF
`define MF2_LOC_CRTC_BASE  13'h1DB0
`define MF2_LOC_PPI        13'h17FF
`define MF2_LOC_ROMSEL     13'h1AAC

`endif

//--- rtl/mf2_pkg.sv
//////////////////////////////////////////////////////////////////////
// Multiface Two shared types
// Bus words, RAM address and the gate array command byte
//////////////////////////////////////////////////////////////////////
`include "mf2_config.svh"

package mf2_pkg;

	typedef logic [15:0] cpu_addr_t;                  // Z80 address bus
	typedef logic [7:0]  byte_t;
	typedef logic [`MF2_RAM_AWIDTH-1:0] mf2_addr_t;   // 8 KB RAM

	//////////////////////////////////////////////////////////////////
	// Gate array command byte
	//////////////////////////////////////////////////////////////////

	// Top two bits pick the function
	localparam logic [1:0] GA_FN_PEN    = 2'b00;
	localparam logic [1:0] GA_FN_COLOUR = 2'b01;
	localparam logic [1:0] GA_FN_MODE   = 2'b10;
	localparam logic [1:0] GA_FN_BANK   = 2'b11;

	typedef struct packed {
		logic [1:0] func;
		logic [5:0] payload;   // pen index sits in bits 4:0
	} ga_cmd_t;

	// Same byte, seen raw for storing or as a command for decoding
	typedef union packed {
		byte_t   raw;
		ga_cmd_t cmd;
	} ga_word_t;

	//////////////////////////////////////////////////////////////////
	// Mode setting
	//////////////////////////////////////////////////////////////////

	// Any other value (2 or 3) disables the block
	localparam logic [1:0] MF2_MODE_ENABLED = 2'd0;
	localparam logic [1:0] MF2_MODE_HIDDEN  = 2'd1;

endpackage

//--- rtl/mf2_io_decode.sv
//////////////////////////////////////////////////////////////////////
// Multiface Two bus decoder
// Maps I/O writes to shadow RAM slots, flags page port writes
// and M1 fetches at the NMI and hide vectors
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "mf2_config.svh"

module mf2_io_decode (
	input  logic                clk_sys,
	input  logic                reset,
	input  mf2_pkg::cpu_addr_t  cpu_addr,
	input  mf2_pkg::byte_t      cpu_dout,
	input  logic                io_wr,
	input  logic                m1,
	output logic                store_wr,
	output mf2_pkg::mf2_addr_t  store_addr,
	output mf2_pkg::byte_t      store_data,
	output logic                page_wr,
	output logic                page_on,
	output logic                m1_nmi_vec,
	output logic                m1_hide_vec
);
	import mf2_pkg::*;

	localparam cpu_addr_t PAGE_PORT = `MF2_PAGE_PORT;

	logic      io_wr_q;
	logic      m1_q;
	ga_word_t  ga_word;
	logic [4:0] pen_index;   // Last selected pen
	logic [3:0] crtc_reg;    // Last selected CRTC register
	mf2_addr_t store_sel;
	logic      store_hit;
	logic      io_rise;
	logic      m1_rise;
	logic      page_hit;

	assign ga_word.raw = cpu_dout;
	assign io_rise     = io_wr & ~io_wr_q;
	assign m1_rise     = m1 & ~m1_q;
	assign page_hit    = (cpu_addr[15:2] == PAGE_PORT[15:2]);  // FEE8 or FEEA

	// Shadow slot for the current I/O write
	always_comb begin
		store_sel = '0;
		store_hit = 1'b1;
		case (cpu_addr[15:8])
			`GA_PORT: begin
				case (ga_word.cmd.func)
					GA_FN_PEN:    store_sel = `MF2_LOC_PEN_INDEX;
					GA_FN_COLOUR: store_sel = pen_index[4] ? `MF2_LOC_BORDER :
						`MF2_LOC_PEN_BASE + mf2_addr_t'(pen_index[3:0]);
					GA_FN_MODE:   store_sel = `MF2_LOC_MODE;
					default:      store_sel = `MF2_LOC_BANKING;
				endcase
			end
			`CRTC_SEL_PORT: store_sel = `MF2_LOC_CRTC_SEL;
			`CRTC_VAL_PORT: store_sel = `MF2_LOC_CRTC_BASE + mf2_addr_t'(crtc_reg);
			`PPI_PORT:      store_sel = `MF2_LOC_PPI;
			`ROMSEL_PORT:   store_sel = `MF2_LOC_ROMSEL;
			default:        store_hit = 1'b0;
		endcase
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			io_wr_q     <= 1'b0;
			m1_q        <= 1'b0;
			store_wr    <= 1'b0;
			page_wr     <= 1'b0;
			m1_nmi_vec  <= 1'b0;
			m1_hide_vec <= 1'b0;
			pen_index   <= '0;
			crtc_reg    <= '0;
		end else begin
			io_wr_q     <= io_wr;
			m1_q        <= m1;
			m1_nmi_vec  <= m1_rise & (cpu_addr == `MF2_NMI_VECTOR);
			m1_hide_vec <= m1_rise & (cpu_addr == `MF2_HIDE_VECTOR);
			page_wr     <= io_rise & page_hit;
			store_wr    <= io_rise & ~page_hit & store_hit;
			if (io_rise && !page_hit) begin
				if (cpu_addr[15:8] == `GA_PORT && ga_word.cmd.func == GA_FN_PEN)
					pen_index <= ga_word.cmd.payload[4:0];
				if (cpu_addr[15:8] == `CRTC_SEL_PORT)
					crtc_reg <= cpu_dout[3:0];
			end
		end
	end

	// Payload for the pulses above
	always_ff @(posedge clk_sys) begin
		if (io_rise) begin
			page_on    <= ~cpu_addr[1];   // FEEA pages off
			store_addr <= store_sel;
			store_data <= ga_word.raw;
		end
	end

endmodule

//--- rtl/mf2_control.sv
//////////////////////////////////////////////////////////////////////
// Multiface Two control
// NMI request, paging enable and hidden state
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module mf2_control (
	input  logic       clk_sys,
	input  logic       reset,
	input  logic       key_nmi,
	input  logic [1:0] mode,
	input  logic       page_wr,
	input  logic       page_on,
	input  logic       m1_nmi_vec,
	input  logic       m1_hide_vec,
	output logic       nmi,
	output logic       mf2_en
);
	import mf2_pkg::*;

	logic key_q;
	logic key_qq;
	logic hidden;
	logic mode_off;
	logic key_rise;

	// Modes 2 and 3 switch the block off
	assign mode_off = (mode != MF2_MODE_ENABLED) && (mode != MF2_MODE_HIDDEN);
	assign key_rise = key_q & ~key_qq;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			key_q  <= 1'b0;
			key_qq <= 1'b0;
			nmi    <= 1'b0;
			mf2_en <= 1'b0;
			hidden <= (mode != MF2_MODE_ENABLED);  // Hidden until first NMI entry
		end else begin
			key_q  <= key_nmi;
			key_qq <= key_q;

			// Stop button
			if (key_rise && !mf2_en && !mode_off)
				nmi <= 1'b1;

			// NMI entry pages the block in and reveals it
			if (nmi && m1_nmi_vec) begin
				mf2_en <= 1'b1;
				hidden <= 1'b0;
				nmi    <= 1'b0;
			end

			if (mf2_en && m1_hide_vec)
				hidden <= 1'b1;

			// Software paging via FEE8/FEEA
			if (page_wr)
				mf2_en <= page_on & ~hidden & ~mode_off;
		end
	end

endmodule

//--- rtl/mf2_shadow_ram.sv
//////////////////////////////////////////////////////////////////////
// Multiface Two RAM
// 8 KB with shadow stores, CPU access and registered read data
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "mf2_config.svh"

module mf2_shadow_ram (
	input  logic                clk_sys,
	input  logic                reset,
	input  mf2_pkg::cpu_addr_t  cpu_addr,
	input  mf2_pkg::byte_t      cpu_dout,
	input  logic                mem_rd,
	input  logic                mem_wr,
	input  logic                mf2_en,
	input  logic                store_wr,
	input  mf2_pkg::mf2_addr_t  store_addr,
	input  mf2_pkg::byte_t      store_data,
	output mf2_pkg::byte_t      mf2_dout
);
	import mf2_pkg::*;

	localparam int unsigned DEPTH = 1 << `MF2_RAM_AWIDTH;

	byte_t     mem [DEPTH];
	mf2_addr_t ram_a;
	byte_t     ram_in;
	byte_t     ram_out;
	logic      ram_we;
	logic      ram_window;
	logic      cpu_we;

	assign ram_window = (cpu_addr[15:13] == `MF2_RAM_WINDOW);
	assign cpu_we     = mem_wr & mf2_en & ram_window;

	always_ff @(posedge clk_sys) begin
		if (reset)
			ram_we <= 1'b0;
		else
			ram_we <= store_wr | cpu_we;
	end

	// Shadow store wins over the CPU
	always_ff @(posedge clk_sys) begin
		if (store_wr) begin
			ram_a  <= store_addr;
			ram_in <= store_data;
		end else begin
			ram_a  <= cpu_addr[`MF2_RAM_AWIDTH-1:0];
			ram_in <= cpu_dout;
		end
	end

	//////////////////////////////////////////////////////////////////
	// Storage array
	//////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (ram_we) begin
			mem[ram_a] <= ram_in;
			ram_out    <= ram_in;   // write-through
		end else begin
			ram_out <= mem[ram_a];
		end
	end

	// Open bus reads as FF
	assign mf2_dout = (mf2_en & mem_rd & ram_window) ? ram_out : 8'hFF;

endmodule

//--- rtl/multiface2.sv
//////////////////////////////////////////////////////////////////////
// Multiface Two
// Stop button NMI, ROM/RAM paging and hardware register shadowing
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "mf2_config.svh"

module multiface2 (
	input  logic                clk_sys,
	input  logic                reset,
	input  mf2_pkg::cpu_addr_t  cpu_addr,
	input  mf2_pkg::byte_t      cpu_dout,
	input  logic                io_wr,
	input  logic                mem_rd,
	input  logic                mem_wr,
	input  logic                m1,
	input  logic                key_nmi,
	input  logic [1:0]          mode,
	output logic                nmi,
	output logic                rom_en,
	output mf2_pkg::byte_t      mf2_dout
);
	import mf2_pkg::*;

	logic      store_wr;
	mf2_addr_t store_addr;
	byte_t     store_data;
	logic      page_wr;
	logic      page_on;
	logic      m1_nmi_vec;
	logic      m1_hide_vec;
	logic      mf2_en;

	// ROM itself is external, only the select leaves here
	assign rom_en = mf2_en & (cpu_addr[15:13] == `MF2_ROM_WINDOW);

	mf2_io_decode io_decode_i (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.cpu_addr    (cpu_addr),
		.cpu_dout    (cpu_dout),
		.io_wr       (io_wr),
		.m1          (m1),
		.store_wr    (store_wr),
		.store_addr  (store_addr),
		.store_data  (store_data),
		.page_wr     (page_wr),
		.page_on     (page_on),
		.m1_nmi_vec  (m1_nmi_vec),
		.m1_hide_vec (m1_hide_vec)
	);

	mf2_control control_i (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.key_nmi     (key_nmi),
		.mode        (mode),
		.page_wr     (page_wr),
		.page_on     (page_on),
		.m1_nmi_vec  (m1_nmi_vec),
		.m1_hide_vec (m1_hide_vec),
		.nmi         (nmi),
		.mf2_en      (mf2_en)
	);

	mf2_shadow_ram shadow_ram_i (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.cpu_addr   (cpu_addr),
		.cpu_dout   (cpu_dout),
		.mem_rd     (mem_rd),
		.mem_wr     (mem_wr),
		.mf2_en     (mf2_en),
		.store_wr   (store_wr),
		.store_addr (store_addr),
		.store_data (store_data),
		.mf2_dout   (mf2_dout)
	);

endmodule

//--- verif/tb_multiface2.sv
//////////////////////////////////////////////////////////////////////
// Multiface Two testbench
// Drives NMI entry, paging, RAM access and register shadowing
// against a reference model of the paging state and RAM
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "mf2_config.svh"

module tb_multiface2;
	import mf2_pkg::*;

	// About 50 checks of 6 cycles plus bus traffic stay below 1000 cycles
	localparam int MAX_CYCLES = 3000;

	logic clk_sys, reset, io_wr, mem_rd, mem_wr, m1, key_nmi;
	logic [1:0] mode;
	cpu_addr_t  cpu_addr;
	byte_t      cpu_dout, mf2_dout;
	logic       nmi, rom_en;

	logic        model_nmi, model_en, model_hidden;
	logic [4:0]  model_pen;
	logic [3:0]  model_crtc;
	byte_t       shadow [8192];
	mf2_addr_t   touched [$];   // Slots hit by I/O stores
	logic [31:0] lfsr_state = 32'hd7c5;
	logic        check_req = 1'b0;
	int          cycles = 0;

	multiface2 dut_i (.clk_sys(clk_sys), .reset(reset), .cpu_addr(cpu_addr),
		.cpu_dout(cpu_dout), .io_wr(io_wr), .mem_rd(mem_rd), .mem_wr(mem_wr),
		.m1(m1), .key_nmi(key_nmi), .mode(mode), .nmi(nmi), .rom_en(rom_en),
		.mf2_dout(mf2_dout));

	always #20 clk_sys = ~clk_sys;

	always @(posedge clk_sys) begin
		cycles = cycles + 1;
		if (cycles >= MAX_CYCLES) begin
			$display("Timeout, the tests did not finish within %0d cycles", MAX_CYCLES);
			$display("sim failed");
			$fatal(1, "Run stopped by the cycle limit");
		end
	end

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
	endfunction

	task automatic take_bits(input int n, output logic [15:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			v = {v[14:0], lfsr_state[0]};   // One step per bit
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Reference model
	//////////////////////////////////////////////////////////////////////

	function automatic logic is_shadow_port(input byte_t port);
		return port == `GA_PORT || port == `CRTC_SEL_PORT || port == `CRTC_VAL_PORT ||
			port == `PPI_PORT || port == `ROMSEL_PORT;
	endfunction

	function automatic mf2_addr_t slot_of(input byte_t port, input byte_t data);
		if (port == `GA_PORT) begin
			case (data[7:6])
				2'b00:   return `MF2_LOC_PEN_INDEX;
				2'b01:   return model_pen[4] ? `MF2_LOC_BORDER : `MF2_LOC_PEN_BASE + model_pen[3:0];
				2'b10:   return `MF2_LOC_MODE;
				default: return `MF2_LOC_BANKING;
			endcase
		end
		if (port == `CRTC_SEL_PORT)
			return `MF2_LOC_CRTC_SEL;
		if (port == `CRTC_VAL_PORT)
			return `MF2_LOC_CRTC_BASE + model_crtc;
		return (port == `PPI_PORT) ? `MF2_LOC_PPI : `MF2_LOC_ROMSEL;
	endfunction

	function automatic logic expected_rom_en(input cpu_addr_t a);
		return model_en && a < 16'h2000;
	endfunction

	function automatic byte_t expected_dout(input cpu_addr_t a, input logic rd);
		if (model_en && rd && a >= 16'h2000 && a < 16'h4000)
			return shadow[a[12:0]];
		return 8'hFF;   // Open bus
	endfunction

	task automatic check_value(input string name, input logic [7:0] got, input logic [7:0] exp);
		if (got !== exp) begin
			$display("Error %s got %h expected %h", name, got, exp);
			$display("sim failed");
			$fatal(1, "Stopping at the first mismatch");
		end
	endtask

	// Compares all outputs while the bus is held still
	always @(posedge check_req) begin
		check_value("nmi", {7'b0, nmi}, {7'b0, model_nmi});
		check_value("rom_en", {7'b0, rom_en}, {7'b0, expected_rom_en(cpu_addr)});
		check_value("mf2_dout", mf2_dout, expected_dout(cpu_addr, mem_rd));
		check_req = 1'b0;
	end

	//////////////////////////////////////////////////////////////////////
	// Bus tasks, each starts and ends on a falling edge
	//////////////////////////////////////////////////////////////////////

	task automatic settle_check();
		repeat (5) @(negedge clk_sys);
		check_req = 1'b1;
		wait (check_req == 1'b0);
	endtask

	task automatic check_at(input cpu_addr_t addr);
		cpu_addr = addr;
		settle_check();
	endtask

	task automatic apply_reset(input logic [1:0] m);
		mode  = m;
		reset = 1'b1;
		repeat (4) @(negedge clk_sys);
		reset        = 1'b0;
		model_nmi    = 1'b0;
		model_en     = 1'b0;
		model_hidden = (m != 2'd0);
	endtask

	task automatic press_nmi();
		key_nmi = 1'b1;
		repeat (3) @(negedge clk_sys);
		key_nmi = 1'b0;
		@(negedge clk_sys);
		if (!model_en && !mode[1])
			model_nmi = 1'b1;
	endtask

	task automatic m1_fetch(input cpu_addr_t addr);
		cpu_addr = addr;
		m1 = 1'b1;
		@(negedge clk_sys);
		m1 = 1'b0;
		@(negedge clk_sys);
		if (addr == `MF2_NMI_VECTOR && model_nmi) begin
			model_en     = 1'b1;
			model_hidden = 1'b0;
			model_nmi    = 1'b0;
		end else if (addr == `MF2_HIDE_VECTOR && model_en) begin
			model_hidden = 1'b1;
		end
	endtask

	task automatic io_write(input cpu_addr_t addr, input byte_t data);
		mf2_addr_t slot;
		cpu_addr = addr;
		cpu_dout = data;
		io_wr    = 1'b1;
		@(negedge clk_sys);
		io_wr = 1'b0;
		@(negedge clk_sys);
		if ((addr & 16'hFFFD) == `MF2_PAGE_PORT) begin   // FEE8 or FEEA
			model_en = !addr[1] && !model_hidden && !mode[1];
		end else if (is_shadow_port(addr[15:8])) begin
			slot         = slot_of(addr[15:8], data);
			shadow[slot] = data;
			touched.push_back(slot);
			if (addr[15:8] == `GA_PORT && data[7:6] == 2'b00)
				model_pen = data[4:0];
			if (addr[15:8] == `CRTC_SEL_PORT)
				model_crtc = data[3:0];
		end
	endtask

	task automatic shadow_write(input byte_t port, input byte_t data);
		logic [15:0] lo;
		take_bits(8, lo);   // Low port byte is don't care
		io_write({port, lo[7:0]}, data);
	endtask

	task automatic mem_write(input cpu_addr_t addr, input byte_t data);
		cpu_addr = addr;
		cpu_dout = data;
		mem_wr   = 1'b1;
		@(negedge clk_sys);
		mem_wr = 1'b0;
		@(negedge clk_sys);
		if (model_en && addr >= 16'h2000 && addr < 16'h4000)
			shadow[addr[12:0]] = data;
	endtask

	task automatic mem_read_check(input cpu_addr_t addr);
		cpu_addr = addr;
		mem_rd   = 1'b1;
		settle_check();
		mem_rd = 1'b0;
	endtask

	initial begin : main_seq
		logic [15:0] r;
		logic [15:0] d;
		cpu_addr_t   written [$];
		clk_sys  = 1'b0;
		reset    = 1'b1;
		io_wr    = 1'b0;
		mem_rd   = 1'b0;
		mem_wr   = 1'b0;
		m1       = 1'b0;
		key_nmi  = 1'b0;
		mode     = 2'd0;
		cpu_addr = 16'h4000;
		cpu_dout = 8'h00;
		model_pen = '0;
		model_crtc = '0;
		@(negedge clk_sys);
		apply_reset(2'd0);
		mem_read_check(16'h2000);

		// NMI entry in mode 0
		press_nmi();
		check_at(16'h4000);
		m1_fetch(`MF2_NMI_VECTOR);
		check_at(16'h0066);
		check_at(16'h1FFF);
		check_at(16'h4000);

		// RAM window read back, then paged off
		for (int n = 0; n < 12; n++) begin
			take_bits(13, r);
			take_bits(8, d);
			mem_write(16'h2000 | r[12:0], d[7:0]);
			written.push_back(16'h2000 | r[12:0]);
		end
		foreach (written[k])
			mem_read_check(written[k]);
		io_write(16'hFEEA, 8'h00);
		for (int k = 0; k < 4; k++)
			mem_read_check(written[k]);

		// Register shadowing while paged out
		for (int n = 0; n < 4; n++) begin
			take_bits(6, r);
			if (n == 0)
				r[4] = 1'b1;   // Border pen
			shadow_write(`GA_PORT, {2'b00, r[5:0]});
			take_bits(6, d);
			shadow_write(`GA_PORT, {2'b01, d[5:0]});
		end
		take_bits(12, r);
		shadow_write(`GA_PORT, {2'b10, r[5:0]});
		shadow_write(`GA_PORT, {2'b11, r[11:6]});
		for (int n = 0; n < 3; n++) begin
			take_bits(16, r);
			shadow_write(`CRTC_SEL_PORT, r[7:0]);
			shadow_write(`CRTC_VAL_PORT, r[15:8]);
		end
		take_bits(16, r);
		shadow_write(`PPI_PORT, r[7:0]);
		shadow_write(`ROMSEL_PORT, r[15:8]);
		io_write(16'hFEE8, 8'h00);
		foreach (touched[k])
			mem_read_check(16'h2000 | touched[k]);

		// Hide vector, then paging has no effect
		m1_fetch(`MF2_HIDE_VECTOR);
		io_write(16'hFEEA, 8'h00);
		io_write(16'hFEE8, 8'h00);
		check_at(16'h0000);

		// Mode 1 starts hidden until NMI entry
		apply_reset(2'd1);
		io_write(16'hFEE8, 8'h00);
		check_at(16'h0000);
		press_nmi();
		m1_fetch(`MF2_NMI_VECTOR);
		check_at(16'h0066);
		io_write(16'hFEEA, 8'h00);
		io_write(16'hFEE8, 8'h00);
		check_at(16'h1000);

		// Mode 2 ignores the button
		apply_reset(2'd2);
		press_nmi();
		io_write(16'hFEE8, 8'h00);
		check_at(16'h0000);

		$display("sim passed");
		$finish;
	end

endmodule

//--- src.f
+incdir+include
rtl/mf2_pkg.sv
rtl/mf2_io_decode.sv
rtl/mf2_control.sv
rtl/mf2_shadow_ram.sv
rtl/multiface2.sv
verif/tb_multiface2.sv
